//--- Bender.yml
package:
  name: hub_memory

sources:
  - src/hub_pkg.sv
  - src/hub_request_stage.sv
  - src/hub_memory.sv
  - src/hub_cog_control.sv
  - src/hub_response_stage.sv
  - src/hub_top.sv
  - target: test
    files:
      - verification/hub_properties.sv
      - verification/tb_hub.sv

//--- sources.f
src/hub_pkg.sv
src/hub_request_stage.sv
src/hub_memory.sv
src/hub_cog_control.sv
src/hub_response_stage.sv
src/hub_top.sv
verification/hub_properties.sv
verification/tb_hub.sv

//--- src/hub_cog_control.sv
/*
 * Cog run state and the COGINIT / COGSTOP hub operations.
 * All cogs are stopped in reset; cog 0 is launched on the first
 * cycle after reset is released.
 * At most one control op arrives per cycle, the request stage sees to it.
 * COGINIT picks the lowest stopped cog out of four only.
 */
`timescale 1ns/1ps

module hub_cog_control (
	input logic clk_in,
	input logic reset_in,
	input logic [hub_pkg::NUM_PORTS-1:0] port_valid_i,
	input hub_pkg::hub_op_t port_op_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_long_t port_wdata_i [hub_pkg::NUM_PORTS],
	output logic [hub_pkg::NUM_COGS-1:0] cog_running_o,
	output hub_pkg::hub_long_t ctrl_result_o [hub_pkg::NUM_PORTS]
);

	logic launch_pending;		// high until cog 0 has been started
	logic free_found;
	hub_pkg::cog_id_t free_cog;
	hub_pkg::cog_id_t stop_cog [hub_pkg::NUM_PORTS];
	logic [hub_pkg::NUM_COGS-1:0] running_next;
	hub_pkg::hub_long_t result_next [hub_pkg::NUM_PORTS];

	// lowest stopped cog, scanned downwards so the lowest assignment sticks
	always_comb
	begin
		free_found = 1'b0;
		free_cog = '0;
		for (int c = hub_pkg::NUM_COGS - 1; c >= 0; c--)
		begin
			if (!cog_running_o[c])
			begin
				free_found = 1'b1;
				free_cog = hub_pkg::cog_id_t'(c);
			end
		end
	end

	always_comb
	begin
		running_next = cog_running_o;
		if (launch_pending)
			running_next[0] = 1'b1;
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			stop_cog[p] = port_wdata_i[p][hub_pkg::COG_ID_WIDTH-1:0];
			result_next[p] = '0;
			if (port_valid_i[p] && port_op_i[p] == hub_pkg::OP_COGINIT)
			begin
				if (free_found)
				begin
					running_next[free_cog] = 1'b1;
					result_next[p] = hub_pkg::hub_long_t'(free_cog);
				end
				else
					result_next[p] = hub_pkg::NO_FREE_COG;
			end
			else if (port_valid_i[p] && port_op_i[p] == hub_pkg::OP_COGSTOP)
			begin
				running_next[stop_cog[p]] = 1'b0;	// self stop allowed
				result_next[p] = hub_pkg::hub_long_t'(stop_cog[p]);
			end
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
		begin
			cog_running_o <= '0;
			launch_pending <= 1'b1;
		end
		else
		begin
			cog_running_o <= running_next;
			launch_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk_in)
	begin
		ctrl_result_o <= result_next;
	end

endmodule

//--- src/hub_memory.sv
/*
 * Dual-port hub RAM, one long wide with byte enables.
 * Reads are registered and return the old long on a same-edge write.
 * When both ports write the same long, the right port's enabled bytes win.
 * No preload: contents are undefined until written.
 */
`timescale 1ns/1ps

module hub_memory #(
	parameter int ADDR_WIDTH = 15
) (
	input logic clk_in,
	input logic [ADDR_WIDTH-1:0] port_addr_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_long_t port_wdata_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_byte_en_t port_byte_en_i [hub_pkg::NUM_PORTS],
	input logic [hub_pkg::NUM_PORTS-1:0] port_write_i,
	input logic [hub_pkg::NUM_PORTS-1:0] port_valid_i,
	input hub_pkg::cog_id_t port_cog_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_op_t port_op_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_size_t port_size_i [hub_pkg::NUM_PORTS],
	input logic [1:0] port_lsb_i [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_long_t rd_long_o [hub_pkg::NUM_PORTS],
	output logic [hub_pkg::NUM_PORTS-1:0] rd_valid_o,
	output hub_pkg::cog_id_t rd_cog_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_op_t rd_op_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_size_t rd_size_o [hub_pkg::NUM_PORTS],
	output logic [1:0] rd_lsb_o [hub_pkg::NUM_PORTS]
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	hub_pkg::hub_long_t mem [DEPTH];

	always_ff @(posedge clk_in)
	begin
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			rd_long_o[p] <= mem[port_addr_i[p]];	// old data on collision
		end
		// higher port index assigned last, so right port wins a clash
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			if (port_write_i[p])
			begin
				for (int l = 0; l < hub_pkg::LANES; l++)
				begin
					if (port_byte_en_i[p][l])
						mem[port_addr_i[p]][8*l +: 8] <= port_wdata_i[p][8*l +: 8];
				end
			end
		end
	end

	// tags follow the read by one stage
	always_ff @(posedge clk_in)
	begin
		rd_valid_o <= port_valid_i;
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			rd_cog_o[p] <= port_cog_i[p];
			rd_op_o[p] <= port_op_i[p];
			rd_size_o[p] <= port_size_i[p];
			rd_lsb_o[p] <= port_lsb_i[p];
		end
	end

endmodule

//--- src/hub_pkg.sv
/*
 * Shared constants and types for the four-cog hub memory.
 * Sized for four cogs on two memory ports, so a cog number is 2 bits
 * and cog c always uses port c mod 2.
 * The long-address width is not defined here. It is a parameter of the
 * top level.
 * The unused size code 2'b11 is handled as a long wherever it is decoded.
 */
package hub_pkg;

	localparam int NUM_COGS = 4;
	localparam int NUM_PORTS = 2;		// left port even cogs, right port odd cogs
	localparam int COG_ID_WIDTH = 2;
	localparam int LANES = 4;		// bytes per long
	localparam int DATA_WIDTH = 32;

	typedef logic [DATA_WIDTH-1:0] hub_long_t;
	typedef logic [LANES-1:0] hub_byte_en_t;
	typedef logic [COG_ID_WIDTH-1:0] cog_id_t;

	// hub operation carried with every request
	typedef enum logic [1:0]
	{
		OP_READ = 2'b00,
		OP_WRITE = 2'b01,
		OP_COGINIT = 2'b10,	// start lowest stopped cog
		OP_COGSTOP = 2'b11	// stop cog in wdata bits 1:0
	} hub_op_t;

	typedef enum logic [1:0]
	{
		SZ_BYTE = 2'b00,
		SZ_WORD = 2'b01,
		SZ_LONG = 2'b10
	} hub_size_t;

	// coginit result when every cog is already running
	localparam hub_long_t NO_FREE_COG = '1;

endpackage

//--- src/hub_request_stage.sv
/*
 * Time-sliced request capture for the hub.
 * A slot bit toggles every cycle; cog c may only be granted on port c mod 2
 * when the slot equals c div 2, it is running and has nothing in flight.
 * req_i is a level and must hold its fields until the ack is seen.
 * Only one control op is granted per edge; the right port gives way.
 */
`timescale 1ns/1ps

module hub_request_stage #(
	parameter int ADDR_WIDTH = 15
) (
	input logic clk_in,
	input logic reset_in,
	input logic [hub_pkg::NUM_COGS-1:0] req_i,
	input hub_pkg::hub_op_t op_i [hub_pkg::NUM_COGS],
	input logic [ADDR_WIDTH+1:0] addr_i [hub_pkg::NUM_COGS],
	input hub_pkg::hub_size_t size_i [hub_pkg::NUM_COGS],
	input hub_pkg::hub_long_t wdata_i [hub_pkg::NUM_COGS],
	input logic [hub_pkg::NUM_COGS-1:0] cog_running_i,
	input logic [hub_pkg::NUM_COGS-1:0] req_done_i,
	output logic [hub_pkg::NUM_PORTS-1:0] port_valid_o,
	output hub_pkg::cog_id_t port_cog_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_op_t port_op_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_size_t port_size_o [hub_pkg::NUM_PORTS],
	output logic [1:0] port_lsb_o [hub_pkg::NUM_PORTS],
	output logic [ADDR_WIDTH-1:0] port_addr_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_long_t port_wdata_o [hub_pkg::NUM_PORTS],
	output hub_pkg::hub_byte_en_t port_byte_en_o [hub_pkg::NUM_PORTS],
	output logic [hub_pkg::NUM_PORTS-1:0] port_write_o
);

	logic slot;
	logic [hub_pkg::NUM_COGS-1:0] pending;		// access in flight per cog
	logic [hub_pkg::NUM_COGS-1:0] grant_cogs;
	logic [hub_pkg::NUM_PORTS-1:0] want;
	logic [hub_pkg::NUM_PORTS-1:0] is_ctrl;
	logic [hub_pkg::NUM_PORTS-1:0] grant;

	hub_pkg::cog_id_t sel_cog [hub_pkg::NUM_PORTS];
	hub_pkg::hub_op_t cur_op [hub_pkg::NUM_PORTS];
	hub_pkg::hub_size_t cur_size [hub_pkg::NUM_PORTS];
	logic [ADDR_WIDTH+1:0] cur_addr [hub_pkg::NUM_PORTS];
	hub_pkg::hub_long_t cur_wdata [hub_pkg::NUM_PORTS];
	hub_pkg::hub_long_t steer_data [hub_pkg::NUM_PORTS];
	hub_pkg::hub_byte_en_t steer_be [hub_pkg::NUM_PORTS];

	// slot owner per port and the grant decision
	always_comb
	begin
		grant_cogs = '0;
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			sel_cog[p] = hub_pkg::cog_id_t'(int'(slot) * hub_pkg::NUM_PORTS + p);
			cur_op[p] = op_i[sel_cog[p]];
			cur_size[p] = size_i[sel_cog[p]];
			cur_addr[p] = addr_i[sel_cog[p]];
			cur_wdata[p] = wdata_i[sel_cog[p]];
			want[p] = req_i[sel_cog[p]] && !pending[sel_cog[p]] &&
				cog_running_i[sel_cog[p]];
			is_ctrl[p] = (cur_op[p] == hub_pkg::OP_COGINIT) ||
				(cur_op[p] == hub_pkg::OP_COGSTOP);
		end
		grant = want;
		if (&want && &is_ctrl)
			grant[hub_pkg::NUM_PORTS-1] = 1'b0;	// right port waits for its next slot
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			if (grant[p])
				grant_cogs[sel_cog[p]] = 1'b1;
		end
	end

	// move byte or word into its lane, form the enables
	always_comb
	begin
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			steer_data[p] = '0;
			steer_be[p] = '0;
			case (cur_size[p])
				hub_pkg::SZ_BYTE:
				begin
					steer_data[p][{cur_addr[p][1:0], 3'b000} +: 8] = cur_wdata[p][7:0];
					steer_be[p][cur_addr[p][1:0]] = 1'b1;
				end
				hub_pkg::SZ_WORD:
				begin
					steer_data[p][{cur_addr[p][1], 4'b0000} +: 16] = cur_wdata[p][15:0];
					steer_be[p][{cur_addr[p][1], 1'b0} +: 2] = 2'b11;	// bit 0 ignored
				end
				default:
				begin
					steer_data[p] = cur_wdata[p];
					steer_be[p] = '1;
				end
			endcase
			if (cur_op[p] != hub_pkg::OP_WRITE)
				steer_data[p] = cur_wdata[p];	// cogstop operand stays unshifted
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
		begin
			slot <= 1'b0;
			pending <= '0;
			port_valid_o <= '0;
			port_write_o <= '0;
		end
		else
		begin
			slot <= ~slot;
			pending <= (pending & ~req_done_i) | grant_cogs;
			for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
			begin
				port_valid_o[p] <= grant[p];
				port_write_o[p] <= grant[p] && (cur_op[p] == hub_pkg::OP_WRITE);
			end
		end
	end

	// request payload, qualified by port_valid_o downstream
	always_ff @(posedge clk_in)
	begin
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			port_cog_o[p] <= sel_cog[p];
			port_op_o[p] <= cur_op[p];
			port_size_o[p] <= cur_size[p];
			port_lsb_o[p] <= cur_addr[p][1:0];
			port_addr_o[p] <= cur_addr[p][ADDR_WIDTH+1:2];	// long address
			port_wdata_o[p] <= steer_data[p];
			port_byte_en_o[p] <= steer_be[p];
		end
	end

endmodule

//--- src/hub_response_stage.sv
/*
 * Returns results to the cogs one cycle after the memory read.
 * Byte and word reads are taken from their lanes and zero-extended.
 * Control ops return the control result; writes leave rdata_o as it was.
 * ack_o is a one-cycle pulse with no back-pressure.
 * req_done_o is combinational so the request stage frees the cog on
 * the same edge that raises its ack.
 */
`timescale 1ns/1ps

module hub_response_stage (
	input logic clk_in,
	input logic reset_in,
	input hub_pkg::hub_long_t rd_long_i [hub_pkg::NUM_PORTS],
	input logic [hub_pkg::NUM_PORTS-1:0] rd_valid_i,
	input hub_pkg::cog_id_t rd_cog_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_op_t rd_op_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_size_t rd_size_i [hub_pkg::NUM_PORTS],
	input logic [1:0] rd_lsb_i [hub_pkg::NUM_PORTS],
	input hub_pkg::hub_long_t ctrl_result_i [hub_pkg::NUM_PORTS],
	output logic [hub_pkg::NUM_COGS-1:0] ack_o,
	output hub_pkg::hub_long_t rdata_o [hub_pkg::NUM_COGS],
	output logic [hub_pkg::NUM_COGS-1:0] req_done_o
);

	hub_pkg::hub_long_t aligned [hub_pkg::NUM_PORTS];
	hub_pkg::hub_long_t result [hub_pkg::NUM_PORTS];
	logic [hub_pkg::NUM_PORTS-1:0] update;		// port carries data back

	always_comb
	begin
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			case (rd_size_i[p])
				hub_pkg::SZ_BYTE:
					aligned[p] = hub_pkg::hub_long_t'(rd_long_i[p][{rd_lsb_i[p], 3'b000} +: 8]);
				hub_pkg::SZ_WORD:
					aligned[p] = hub_pkg::hub_long_t'(rd_long_i[p][{rd_lsb_i[p][1], 4'b0000} +: 16]);
				default:
					aligned[p] = rd_long_i[p];	// long, low bits ignored
			endcase
			if (rd_op_i[p] == hub_pkg::OP_READ)
				result[p] = aligned[p];
			else
				result[p] = ctrl_result_i[p];
			update[p] = rd_valid_i[p] && (rd_op_i[p] != hub_pkg::OP_WRITE);
		end
	end

	always_comb
	begin
		req_done_o = '0;
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			if (rd_valid_i[p])
				req_done_o[rd_cog_i[p]] = 1'b1;
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
			ack_o <= '0;
		else
			ack_o <= req_done_o;
	end

	// each cog only ever appears on its own port
	always_ff @(posedge clk_in)
	begin
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			if (update[p])
				rdata_o[rd_cog_i[p]] <= result[p];
		end
	end

endmodule

//--- src/hub_top.sv
/*
 * Hub memory shared by four cogs over two time-sliced RAM ports.
 * ack_o follows the grant edge by exactly two cycles; the grant itself
 * waits up to one cycle for the cog's slot.
 * cog_reset_o is high for every stopped cog; only cog 0 is started after
 * reset, the others through COGINIT.
 * Byte addresses are ADDR_WIDTH+2 bits wide.
 */
`timescale 1ns/1ps

module hub_top #(
	parameter int ADDR_WIDTH = 15		// long address width, 32k longs
) (
	input logic clk_in,
	input logic reset_in,
	input logic [hub_pkg::NUM_COGS-1:0] req_i,
	input hub_pkg::hub_op_t op_i [hub_pkg::NUM_COGS],
	input logic [ADDR_WIDTH+1:0] addr_i [hub_pkg::NUM_COGS],
	input hub_pkg::hub_size_t size_i [hub_pkg::NUM_COGS],
	input hub_pkg::hub_long_t wdata_i [hub_pkg::NUM_COGS],
	output logic [hub_pkg::NUM_COGS-1:0] ack_o,
	output hub_pkg::hub_long_t rdata_o [hub_pkg::NUM_COGS],
	output logic [hub_pkg::NUM_COGS-1:0] cog_reset_o
);

	logic [hub_pkg::NUM_COGS-1:0] cog_running;
	logic [hub_pkg::NUM_COGS-1:0] req_done;

	// request stage to memory and cog control
	logic [hub_pkg::NUM_PORTS-1:0] port_valid;
	logic [hub_pkg::NUM_PORTS-1:0] port_write;
	hub_pkg::cog_id_t port_cog [hub_pkg::NUM_PORTS];
	hub_pkg::hub_op_t port_op [hub_pkg::NUM_PORTS];
	hub_pkg::hub_size_t port_size [hub_pkg::NUM_PORTS];
	logic [1:0] port_lsb [hub_pkg::NUM_PORTS];
	logic [ADDR_WIDTH-1:0] port_addr [hub_pkg::NUM_PORTS];
	hub_pkg::hub_long_t port_wdata [hub_pkg::NUM_PORTS];
	hub_pkg::hub_byte_en_t port_byte_en [hub_pkg::NUM_PORTS];

	// memory and cog control to response stage
	hub_pkg::hub_long_t rd_long [hub_pkg::NUM_PORTS];
	logic [hub_pkg::NUM_PORTS-1:0] rd_valid;
	hub_pkg::cog_id_t rd_cog [hub_pkg::NUM_PORTS];
	hub_pkg::hub_op_t rd_op [hub_pkg::NUM_PORTS];
	hub_pkg::hub_size_t rd_size [hub_pkg::NUM_PORTS];
	logic [1:0] rd_lsb [hub_pkg::NUM_PORTS];
	hub_pkg::hub_long_t ctrl_result [hub_pkg::NUM_PORTS];

	assign cog_reset_o = ~cog_running;	// resets are active high

	hub_request_stage #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) hub_request_stage_inst (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.req_i(req_i),
		.op_i(op_i),
		.addr_i(addr_i),
		.size_i(size_i),
		.wdata_i(wdata_i),
		.cog_running_i(cog_running),
		.req_done_i(req_done),
		.port_valid_o(port_valid),
		.port_cog_o(port_cog),
		.port_op_o(port_op),
		.port_size_o(port_size),
		.port_lsb_o(port_lsb),
		.port_addr_o(port_addr),
		.port_wdata_o(port_wdata),
		.port_byte_en_o(port_byte_en),
		.port_write_o(port_write)
	);

	hub_memory #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) hub_memory_inst (
		.clk_in(clk_in),
		.port_addr_i(port_addr),
		.port_wdata_i(port_wdata),
		.port_byte_en_i(port_byte_en),
		.port_write_i(port_write),
		.port_valid_i(port_valid),
		.port_cog_i(port_cog),
		.port_op_i(port_op),
		.port_size_i(port_size),
		.port_lsb_i(port_lsb),
		.rd_long_o(rd_long),
		.rd_valid_o(rd_valid),
		.rd_cog_o(rd_cog),
		.rd_op_o(rd_op),
		.rd_size_o(rd_size),
		.rd_lsb_o(rd_lsb)
	);

	hub_cog_control hub_cog_control_inst (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.port_valid_i(port_valid),
		.port_op_i(port_op),
		.port_wdata_i(port_wdata),
		.cog_running_o(cog_running),
		.ctrl_result_o(ctrl_result)
	);

	hub_response_stage hub_response_stage_inst (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.rd_long_i(rd_long),
		.rd_valid_i(rd_valid),
		.rd_cog_i(rd_cog),
		.rd_op_i(rd_op),
		.rd_size_i(rd_size),
		.rd_lsb_i(rd_lsb),
		.ctrl_result_i(ctrl_result),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.req_done_o(req_done)
	);

endmodule

//--- verification/hub_properties.sv
/*
 * Concurrent checks on the hub top-level ports, bound into hub_top.
 * Every failed assertion also bumps assert_failures, which the testbench
 * reads at the end of the run.
 * The ack check assumes no cog is stopped while it has an access in flight.
 */
`timescale 1ns/1ps

module hub_properties (
	input logic clk_in,
	input logic reset_in,
	input logic [hub_pkg::NUM_COGS-1:0] ack_i,
	input logic [hub_pkg::NUM_COGS-1:0] cog_reset_i
);

	int assert_failures = 0;

	for (genvar c = 0; c < hub_pkg::NUM_COGS; c++)
	begin : g_cog
		assert property (@(posedge clk_in) disable iff (reset_in) ack_i[c] |=> !ack_i[c])
		else
		begin
			$error("ack held high for two cycles on cog %0d", c);
			assert_failures++;
		end

		assert property (@(posedge clk_in) ack_i[c] |-> !cog_reset_i[c])
		else
		begin
			$error("ack raised for cog %0d while it is in reset", c);
			assert_failures++;
		end
	end

	assert property (@(posedge clk_in) reset_in |=> &cog_reset_i)
	else
	begin
		$error("a cog left reset while the hub was in reset");
		assert_failures++;
	end

	// cog 0 launch right after release
	assert property (@(posedge clk_in) $fell(reset_in) |=> !cog_reset_i[0])
	else
	begin
		$error("cog 0 was not launched after reset");
		assert_failures++;
	end

endmodule

bind hub_top hub_properties hub_properties_inst (
	.clk_in(clk_in),
	.reset_in(reset_in),
	.ack_i(ack_o),
	.cog_reset_i(cog_reset_o)
);

//--- verification/tb_hub.sv
/*
 * Self-checking testbench for the four-cog hub memory.
 * All traffic stays in a 16-long window that cog 0 fills first, so the
 * model never has to predict unwritten memory.
 * Control ops come from cog 0 only; the random phase is reads and writes.
 * No cog stops itself or a cog with an access in flight.
 */
`timescale 1ns/1ps

module tb_hub;

	localparam int ADDR_WIDTH = 15;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int WINDOW_LONGS = 16;
	localparam int WINDOW_BASE = 'h240;	// byte address, long aligned
	localparam int LONG_PAIRS = 8;
	localparam int MIX_ROUNDS = 16;
	localparam int RANDOM_OPS = 60;		// per cog
	localparam int DIRECT_ACCESSES = WINDOW_LONGS + 2 * LONG_PAIRS + 3 * MIX_ROUNDS + 6;
	localparam int TEST_CYCLES = RESET_CYCLES + DIRECT_ACCESSES +
		hub_pkg::NUM_COGS * RANDOM_OPS;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES * 20 + 200;

	typedef struct packed
	{
		hub_pkg::hub_op_t op;
		hub_pkg::hub_size_t size;
		logic [ADDR_WIDTH+1:0] addr;
		hub_pkg::hub_long_t wdata;
		int exp_ack;		// cycle count when the ack is due
	} access_t;

	logic clk_in;
	logic reset_in;
	logic [hub_pkg::NUM_COGS-1:0] req_i;
	hub_pkg::hub_op_t op_i [hub_pkg::NUM_COGS];
	logic [ADDR_WIDTH+1:0] addr_i [hub_pkg::NUM_COGS];
	hub_pkg::hub_size_t size_i [hub_pkg::NUM_COGS];
	hub_pkg::hub_long_t wdata_i [hub_pkg::NUM_COGS];
	logic [hub_pkg::NUM_COGS-1:0] ack_o;
	hub_pkg::hub_long_t rdata_o [hub_pkg::NUM_COGS];
	logic [hub_pkg::NUM_COGS-1:0] cog_reset_o;

	logic [7:0] model_mem [WINDOW_LONGS * hub_pkg::LANES];
	logic [hub_pkg::NUM_COGS-1:0] model_running;
	hub_pkg::hub_long_t last_rdata [hub_pkg::NUM_COGS];
	access_t accepted_q [hub_pkg::NUM_COGS][$];
	int cycle_count;
	int release_cycle;		// cycle in which reset_in was dropped
	string test_name;

	hub_top #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) hub_top_inst (
		.clk_in(clk_in),
		.reset_in(reset_in),
		.req_i(req_i),
		.op_i(op_i),
		.addr_i(addr_i),
		.size_i(size_i),
		.wdata_i(wdata_i),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.cog_reset_o(cog_reset_o)
	);

	initial
	begin
		clk_in = 1'b0;
		forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
	end

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk_in);
			cycle_count++;
		end
	end

	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_long(hub_pkg::hub_long_t expected, hub_pkg::hub_long_t actual);
		if (actual !== expected)
		begin
			$display("ERR %s: rdata expected %h, actual %h", test_name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_ack_cycle(int expected, int actual);
		if (actual != expected)
		begin
			$display("ERR %s: ack cycle expected %0d, actual %0d", test_name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_cog_reset(logic [hub_pkg::NUM_COGS-1:0] expected,
		logic [hub_pkg::NUM_COGS-1:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %s: cog_reset expected %b, actual %b", test_name, expected, actual);
			stop_run();
		end
	endtask

	function automatic logic [ADDR_WIDTH+1:0] random_addr();
		return WINDOW_BASE + $urandom_range(0, WINDOW_LONGS * hub_pkg::LANES - 1);
	endfunction

	// little endian lanes, word ignores bit 0, long ignores bits 1:0
	function automatic hub_pkg::hub_long_t model_read(access_t rec);
		int base;
		int lane;
		hub_pkg::hub_long_t value;
		base = (int'(rec.addr) - WINDOW_BASE) & ~3;
		lane = int'(rec.addr) & 3;
		value = '0;
		case (rec.size)
			hub_pkg::SZ_BYTE:
				value[7:0] = model_mem[base + lane];
			hub_pkg::SZ_WORD:
				value[15:0] = {model_mem[base + (lane & 2) + 1], model_mem[base + (lane & 2)]};
			default:
			begin
				for (int b = 0; b < hub_pkg::LANES; b++)
					value[8*b +: 8] = model_mem[base + b];
			end
		endcase
		return value;
	endfunction

	task automatic apply_write(access_t rec);
		int base;
		int lane;
		base = (int'(rec.addr) - WINDOW_BASE) & ~3;
		lane = int'(rec.addr) & 3;
		case (rec.size)
			hub_pkg::SZ_BYTE:
				model_mem[base + lane] = rec.wdata[7:0];
			hub_pkg::SZ_WORD:
			begin
				model_mem[base + (lane & 2)] = rec.wdata[7:0];
				model_mem[base + (lane & 2) + 1] = rec.wdata[15:8];
			end
			default:
			begin
				for (int b = 0; b < hub_pkg::LANES; b++)
					model_mem[base + b] = rec.wdata[8*b +: 8];
			end
		endcase
	endtask

	// reads and control ops, both return a value to the cog
	task automatic finish_request(int cog, access_t rec);
		hub_pkg::hub_long_t expected;
		logic found;
		if (rec.op == hub_pkg::OP_READ)
			expected = model_read(rec);
		else if (rec.op == hub_pkg::OP_COGINIT)
		begin
			found = 1'b0;
			expected = hub_pkg::NO_FREE_COG;
			for (int n = 0; n < hub_pkg::NUM_COGS; n++)
			begin
				if (!found && !model_running[n])
				begin
					found = 1'b1;
					expected = n;
					model_running[n] = 1'b1;
				end
			end
		end
		else
		begin
			expected = rec.wdata[hub_pkg::COG_ID_WIDTH-1:0];
			model_running[rec.wdata[hub_pkg::COG_ID_WIDTH-1:0]] = 1'b0;
		end
		check_long(expected, rdata_o[cog]);
		if (rec.op != hub_pkg::OP_READ)
			check_cog_reset(~model_running, cog_reset_o);
		last_rdata[cog] = expected;
	endtask

	// all acks of one cycle share one grant edge
	task automatic check_acks();
		access_t rec [hub_pkg::NUM_COGS];
		logic [hub_pkg::NUM_COGS-1:0] seen;
		seen = ack_o;
		for (int c = 0; c < hub_pkg::NUM_COGS; c++)
		begin
			if (seen[c] && accepted_q[c].size() == 0)
			begin
				$display("%s: cog %0d got an ack with no request outstanding", test_name, c);
				stop_run();
			end
			else if (seen[c])
			begin
				rec[c] = accepted_q[c].pop_front();
				check_ack_cycle(rec[c].exp_ack, cycle_count);
			end
		end
		for (int c = 0; c < hub_pkg::NUM_COGS; c++)
		begin
			if (seen[c] && rec[c].op != hub_pkg::OP_WRITE)
				finish_request(c, rec[c]);	// old data before same-edge writes
		end
		for (int p = 0; p < hub_pkg::NUM_PORTS; p++)
		begin
			for (int c = p; c < hub_pkg::NUM_COGS; c += hub_pkg::NUM_PORTS)
			begin
				if (seen[c] && rec[c].op == hub_pkg::OP_WRITE)
				begin
					apply_write(rec[c]);	// right port lands last
					check_long(last_rdata[c], rdata_o[c]);
				end
			end
		end
	endtask

	// called just after a clock edge; returns one cycle after the ack
	task automatic run_access(int cog, hub_pkg::hub_op_t op, hub_pkg::hub_size_t size,
		logic [ADDR_WIDTH+1:0] addr, hub_pkg::hub_long_t wdata);
		access_t rec;
		int first_edge;
		first_edge = cycle_count + 1;
		rec.op = op;
		rec.size = size;
		rec.addr = addr;
		rec.wdata = wdata;
		if ((first_edge - release_cycle - 1) % 2 == cog / hub_pkg::NUM_PORTS)
			rec.exp_ack = first_edge + 2;
		else
			rec.exp_ack = first_edge + 3;	// waits one cycle for its slot
		accepted_q[cog].push_back(rec);
		op_i[cog] = op;
		size_i[cog] = size;
		addr_i[cog] = addr;
		wdata_i[cog] = wdata;
		req_i[cog] = 1'b1;
		do
		begin
			@(posedge clk_in);
			#1;
		end
		while (!ack_o[cog]);
		req_i[cog] = 1'b0;
		@(posedge clk_in);
		#1;
	endtask

	task automatic random_traffic(int cog);
		hub_pkg::hub_op_t op;
		hub_pkg::hub_size_t size;
		repeat (RANDOM_OPS)
		begin
			op = ($urandom_range(0, 1) == 0) ? hub_pkg::OP_READ : hub_pkg::OP_WRITE;
			size = hub_pkg::hub_size_t'($urandom_range(0, 2));
			run_access(cog, op, size, random_addr(), $urandom());
			repeat ($urandom_range(0, 2))
			begin
				@(posedge clk_in);
				#1;
			end
		end
	endtask

	initial
	begin
		forever
		begin
			@(posedge clk_in);
			#1;
			check_acks();
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_in);
		$display("watchdog expired, the hub stopped answering requests");
		stop_run();
	end

	initial
	begin
		logic [ADDR_WIDTH+1:0] addr;
		hub_pkg::hub_size_t size;
		hub_pkg::hub_long_t data;
		void'($urandom(13067));
		reset_in = 1'b1;
		req_i = '0;
		for (int c = 0; c < hub_pkg::NUM_COGS; c++)
		begin
			op_i[c] = hub_pkg::OP_READ;
			addr_i[c] = '0;
			size_i[c] = hub_pkg::SZ_LONG;
			wdata_i[c] = '0;
		end
		model_running = '0;
		release_cycle = 0;
		test_name = "reset";
		repeat (RESET_CYCLES)
		begin
			@(posedge clk_in);
			#1;
			check_cog_reset('1, cog_reset_o);
		end
		reset_in = 1'b0;
		release_cycle = cycle_count;
		@(posedge clk_in);
		#1;
		model_running = 4'b0001;	// only cog 0 launched
		check_cog_reset(4'b1110, cog_reset_o);

		test_name = "fill";
		for (int l = 0; l < WINDOW_LONGS; l++)
			run_access(0, hub_pkg::OP_WRITE, hub_pkg::SZ_LONG, WINDOW_BASE + 4 * l, $urandom());

		test_name = "long_write_read";
		repeat (LONG_PAIRS)
		begin
			addr = random_addr();
			data = $urandom();
			run_access(0, hub_pkg::OP_WRITE, hub_pkg::SZ_LONG, addr, data);
			run_access(0, hub_pkg::OP_READ, hub_pkg::SZ_LONG, addr, '0);
		end

		test_name = "byte_word_lanes";
		repeat (MIX_ROUNDS)
		begin
			addr = random_addr();
			size = ($urandom_range(0, 1) == 0) ? hub_pkg::SZ_BYTE : hub_pkg::SZ_WORD;
			run_access(0, hub_pkg::OP_WRITE, size, addr, $urandom());
			addr[1:0] = 2'($urandom_range(0, 3));
			run_access(0, hub_pkg::OP_READ, hub_pkg::hub_size_t'($urandom_range(0, 1)), addr, '0);
			run_access(0, hub_pkg::OP_READ, hub_pkg::SZ_LONG, addr, '0);	// shows the merge
		end

		test_name = "cog_control";
		repeat (4)
			run_access(0, hub_pkg::OP_COGINIT, hub_pkg::SZ_LONG, '0, '0);	// 1, 2, 3, none
		run_access(0, hub_pkg::OP_COGSTOP, hub_pkg::SZ_LONG, '0, 32'd2);
		run_access(0, hub_pkg::OP_COGINIT, hub_pkg::SZ_LONG, '0, '0);

		test_name = "random_traffic";
		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
			random_traffic(3);
		join

		test_name = "end_of_run";
		for (int c = 0; c < hub_pkg::NUM_COGS; c++)
		begin
			if (accepted_q[c].size() != 0)
			begin
				$display("cog %0d still has requests that were never acknowledged", c);
				stop_run();
			end
		end
		if (hub_top_inst.hub_properties_inst.assert_failures == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("the bound port assertions reported failures");
			stop_run();
		end
	end

endmodule
